//--- hdl/framebuffer_fetch.sv
// --------------------------------------------------------------------------
// framebuffer fetch: ram address, fetch timer and pixel pair capture
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module framebuffer_fetch (
    input  logic                       clk_in,
    input  logic                       reset,
    input  led_panel_pkg::scan_pos_t   scan_pos,
    input  logic                       load_start,
    input  led_panel_pkg::ram_word_t   ram_data,
    output led_panel_pkg::mem_addr_t   ram_address,
    output logic                       ram_clk_enable,
    output led_panel_pkg::pixel_pair_t pixels
);
    import led_panel_pkg::*;

    localparam int timer_width = $clog2(fetch_cycles + 1);
    // read data is registered one cycle after load, so grab it on the next count
    localparam logic [timer_width-1:0] capture_count = timer_width'(fetch_cycles - 1);

    logic [timer_width-1:0] fetch_count;

    assign ram_address = {scan_pos.row, scan_pos.col};

    timeout #(
        .counter_width(timer_width)
    ) fetch_timer (
        .clk_in (clk_in),
        .reset  (reset),
        .start  (load_start),
        .value  (timer_width'(fetch_cycles)),
        .counter(fetch_count),
        .running(ram_clk_enable)
    );

    always_ff @(posedge clk_in) begin
        if (reset) begin
            pixels <= '0;
        end else if (fetch_count == capture_count) begin
            pixels.top    <= ram_data[15:0];
            pixels.bottom <= ram_data[31:16];
        end
    end

endmodule

`default_nettype wire

//--- hdl/framebuffer_ram.sv
// --------------------------------------------------------------------------
// framebuffer memory, host write port and clock-enabled read port
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module framebuffer_ram (
    input  logic                     clk_in,
    input  logic                     wr_en,
    input  led_panel_pkg::mem_addr_t wr_addr,
    input  led_panel_pkg::ram_word_t wr_data,
    input  logic                     rd_en,
    input  led_panel_pkg::mem_addr_t rd_addr,
    output led_panel_pkg::ram_word_t rd_data
);
    import led_panel_pkg::*;

    // one word per row and column of a half panel
    localparam int depth = 2 ** $bits(mem_addr_t);

    ram_word_t mem [depth];

    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // output holds its value while the fetch timer is idle
    always_ff @(posedge clk_in) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

//--- hdl/hub75_shifter.sv
// --------------------------------------------------------------------------
// hub75 output side: colour pins, panel clock, latch, output enable,
// row address and frame done
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module hub75_shifter (
    input  logic                       clk_in,
    input  logic                       reset,
    input  led_panel_pkg::pixel_pair_t pixels,
    input  logic                       pixel_strobe,
    input  logic                       row_end,
    input  logic                       frame_busy,
    input  led_panel_pkg::row_addr_t   scan_row,
    output led_panel_pkg::rgb_bits_t   rgb_top,
    output led_panel_pkg::rgb_bits_t   rgb_bottom,
    output logic                       panel_clk,
    output logic                       latch,
    output logic                       oe_n,
    output led_panel_pkg::row_addr_t   row_out,
    output logic                       frame_done
);
    import led_panel_pkg::*;

    localparam row_addr_t last_row = row_addr_t'(panel_half_height - 1);

    logic      shift_pending;
    logic [1:0] latch_delay;
    logic      latch_fire;
    // row that was just shifted, held until its latch
    row_addr_t row_pending;

    // msb of each colour channel only
    function automatic rgb_bits_t msb_bits(input pixel_t p);
        return {p[15], p[10], p[4]};
    endfunction

    assign latch_fire = (latch_delay == 2'd1);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            rgb_top       <= '0;
            rgb_bottom    <= '0;
            shift_pending <= 1'b0;
            panel_clk     <= 1'b0;
            latch_delay   <= 2'd0;
            row_pending   <= '0;
            latch         <= 1'b0;
            oe_n          <= 1'b1;
            row_out       <= '0;
            frame_done    <= 1'b0;
        end else begin
            // data first with clock low, then one cycle of clock high
            shift_pending <= pixel_strobe;
            panel_clk     <= shift_pending;
            if (pixel_strobe) begin
                rgb_top    <= msb_bits(pixels.top);
                rgb_bottom <= msb_bits(pixels.bottom);
            end
            if (row_end) begin
                latch_delay <= 2'd3;
                row_pending <= scan_row;
            end else if (latch_delay != 2'd0) begin
                latch_delay <= latch_delay - 2'd1;
            end
            latch <= latch_fire;
            if (latch_fire) begin
                row_out <= row_pending;
            end
            // blank outside a frame and while latching
            oe_n       <= !frame_busy || latch_fire;
            frame_done <= latch && (row_out == last_row);
        end
    end

endmodule

`default_nettype wire

//--- hdl/led_panel_pkg.sv
// --------------------------------------------------------------------------
// panel geometry, address and pixel types, scan position and pixel pair
// structs, sequencer state encoding
// --------------------------------------------------------------------------
`default_nettype none

package led_panel_pkg;

    localparam int panel_width       = 64;
    localparam int panel_half_height = 16;
    localparam int fetch_cycles      = 3;

    typedef logic [5:0]  col_addr_t;
    typedef logic [3:0]  row_addr_t;
    // row in the upper bits, column in the lower bits
    typedef logic [9:0]  mem_addr_t;
    // rgb565: red 15..11, green 10..5, blue 4..0
    typedef logic [15:0] pixel_t;
    // bottom pixel high, top pixel low
    typedef logic [31:0] ram_word_t;
    // red, green, blue msb first
    typedef logic [2:0]  rgb_bits_t;

    typedef struct packed {
        pixel_t bottom;
        pixel_t top;
    } pixel_pair_t;

    typedef struct packed {
        row_addr_t row;
        col_addr_t col;
    } scan_pos_t;

    typedef enum logic [1:0] {
        idle,
        slot,
        frame_end
    } seq_state_t;

endpackage

`default_nettype wire

//--- hdl/led_panel_top.sv
// --------------------------------------------------------------------------
// led panel top: sequencer, fetch, framebuffer ram and hub75 shifter
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module led_panel_top (
    input  logic                     clk_in,
    input  logic                     reset,
    input  logic                     frame_start,
    input  logic                     wr_en,
    input  led_panel_pkg::mem_addr_t wr_addr,
    input  led_panel_pkg::ram_word_t wr_data,
    output led_panel_pkg::rgb_bits_t rgb_top,
    output led_panel_pkg::rgb_bits_t rgb_bottom,
    output logic                     panel_clk,
    output logic                     latch,
    output logic                     oe_n,
    output led_panel_pkg::row_addr_t row_out,
    output logic                     frame_done
);
    import led_panel_pkg::*;

    scan_pos_t   scan_pos;
    logic        load_start;
    logic        pixel_strobe;
    logic        row_end;
    logic        frame_busy;
    mem_addr_t   ram_address;
    logic        ram_clk_enable;
    ram_word_t   ram_data;
    pixel_pair_t pixels;

    scan_sequencer i_scan_sequencer (
        .clk_in      (clk_in),
        .reset       (reset),
        .frame_start (frame_start),
        .scan_pos    (scan_pos),
        .load_start  (load_start),
        .pixel_strobe(pixel_strobe),
        .row_end     (row_end),
        .frame_busy  (frame_busy)
    );

    framebuffer_fetch i_framebuffer_fetch (
        .clk_in        (clk_in),
        .reset         (reset),
        .scan_pos      (scan_pos),
        .load_start    (load_start),
        .ram_data      (ram_data),
        .ram_address   (ram_address),
        .ram_clk_enable(ram_clk_enable),
        .pixels        (pixels)
    );

    framebuffer_ram i_framebuffer_ram (
        .clk_in (clk_in),
        .wr_en  (wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .rd_en  (ram_clk_enable),
        .rd_addr(ram_address),
        .rd_data(ram_data)
    );

    hub75_shifter i_hub75_shifter (
        .clk_in      (clk_in),
        .reset       (reset),
        .pixels      (pixels),
        .pixel_strobe(pixel_strobe),
        .row_end     (row_end),
        .frame_busy  (frame_busy),
        .scan_row    (scan_pos.row),
        .rgb_top     (rgb_top),
        .rgb_bottom  (rgb_bottom),
        .panel_clk   (panel_clk),
        .latch       (latch),
        .oe_n        (oe_n),
        .row_out     (row_out),
        .frame_done  (frame_done)
    );

endmodule

`default_nettype wire

//--- hdl/scan_sequencer.sv
// --------------------------------------------------------------------------
// scan sequencer: walks row pairs and columns in four-cycle pixel slots
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module scan_sequencer (
    input  logic                    clk_in,
    input  logic                    reset,
    input  logic                    frame_start,
    output led_panel_pkg::scan_pos_t scan_pos,
    output logic                    load_start,
    output logic                    pixel_strobe,
    output logic                    row_end,
    output logic                    frame_busy
);
    import led_panel_pkg::*;

    localparam col_addr_t last_col = col_addr_t'(panel_width - 1);
    localparam row_addr_t last_row = row_addr_t'(panel_half_height - 1);

    seq_state_t state;
    logic [1:0] slot_cnt;
    // one dead cycle between rows
    logic       row_gap;
    logic       slot_active;

    assign slot_active  = (state == slot) && !row_gap;
    assign load_start   = slot_active && (slot_cnt == 2'd0);
    assign pixel_strobe = slot_active && (slot_cnt == 2'd3);
    assign row_end      = pixel_strobe && (scan_pos.col == last_col);
    assign frame_busy   = (state != idle);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state    <= idle;
            slot_cnt <= 2'd0;
            row_gap  <= 1'b0;
            scan_pos <= '0;
        end else begin
            case (state)
                idle: begin
                    // start strobes are only taken here
                    if (frame_start) begin
                        state    <= slot;
                        slot_cnt <= 2'd0;
                        row_gap  <= 1'b0;
                        scan_pos <= '0;
                    end
                end
                slot: begin
                    if (row_gap) begin
                        row_gap <= 1'b0;
                    end else begin
                        slot_cnt <= slot_cnt + 2'd1;
                        if (slot_cnt == 2'd3) begin
                            if (scan_pos.col == last_col) begin
                                scan_pos.col <= '0;
                                if (scan_pos.row == last_row) begin
                                    // frame_end doubles as the last row gap
                                    state <= frame_end;
                                end else begin
                                    scan_pos.row <= scan_pos.row + row_addr_t'(1);
                                    row_gap      <= 1'b1;
                                end
                            end else begin
                                scan_pos.col <= scan_pos.col + col_addr_t'(1);
                            end
                        end
                    end
                end
                frame_end: begin
                    state <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/timeout.sv
// --------------------------------------------------------------------------
// down-counting timer, loaded on start, running while nonzero
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module timeout #(
    parameter int counter_width = 2
) (
    input  logic                     clk_in,
    input  logic                     reset,
    input  logic                     start,
    input  logic [counter_width-1:0] value,
    output logic [counter_width-1:0] counter,
    output logic                     running
);

    assign running = (counter != '0);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            counter <= '0;
        end else if (start) begin
            counter <= value;
        end else if (running) begin
            // stops at zero until the next start
            counter <= counter - counter_width'(1);
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# verilator build and run of the led panel testbench

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert --top-module led_panel_tb \
    -Mdir "$build_dir" -o led_panel_sim -f sources.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/led_panel_sim" +verilator+error+limit+100 > "$log_file" 2>&1
if [ $? -ne 0 ]; then
    cat "$log_file"
    echo "simulation exited with an error status"
    exit 1
fi
cat "$log_file"

if grep -q "All tests passed" "$log_file"; then
    exit 0
fi
echo "pass message not found in $log_file"
exit 1

//--- sources.f
hdl/led_panel_pkg.sv
hdl/timeout.sv
hdl/scan_sequencer.sv
hdl/framebuffer_fetch.sv
hdl/framebuffer_ram.sv
hdl/hub75_shifter.sv
hdl/led_panel_top.sv
test/tb_clock_gen.sv
test/panel_checker.sv
test/led_panel_asserts.sv
test/led_panel_tb.sv

//--- test/led_panel_asserts.sv
// --------------------------------------------------------------------------
// concurrent assertions on latch, panel clock, output enable and the
// fetch window, bound into the top level
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module led_panel_asserts (
    input logic clk_in,
    input logic reset,
    input logic panel_clk,
    input logic latch,
    input logic oe_n,
    input logic load_start,
    input logic ram_clk_enable
);

    int latch_failures = 0;
    int blank_failures = 0;
    int fetch_failures = 0;

    latch_clk_apart: assert property (@(posedge clk_in) disable iff (reset)
        !(latch && panel_clk))
        else begin
            $error("latch and panel_clk high in the same cycle");
            latch_failures++;
        end

    oe_high_in_latch: assert property (@(posedge clk_in) disable iff (reset)
        latch |-> oe_n)
        else begin
            $error("oe_n low during latch");
            blank_failures++;
        end

    // ram enable covers exactly the three cycles after each load
    fetch_window: assert property (@(posedge clk_in) disable iff (reset)
        ram_clk_enable == ($past(load_start, 1) || $past(load_start, 2)
                           || $past(load_start, 3)))
        else begin
            $error("ram_clk_enable outside the three cycles after load_start");
            fetch_failures++;
        end

endmodule

bind led_panel_top led_panel_asserts i_led_panel_asserts (
    .clk_in        (clk_in),
    .reset         (reset),
    .panel_clk     (panel_clk),
    .latch         (latch),
    .oe_n          (oe_n),
    .load_start    (load_start),
    .ram_clk_enable(ram_clk_enable)
);

`default_nettype wire

//--- test/led_panel_tb.sv
// --------------------------------------------------------------------------
// led panel testbench: test table, lcg fill, write driver, frame loop,
// watchdog and final report
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module led_panel_tb;
    import led_panel_pkg::*;

    typedef enum int {
        fill_zeros,
        fill_ones,
        fill_ramp,
        fill_lcg
    } fill_t;
    typedef logic [1:0] test_index_t;

    localparam int num_tests        = 4;
    localparam int write_cycles     = panel_width * panel_half_height;
    localparam int frame_cycles_max = 4200;
    localparam int settle_cycles    = 40;
    localparam int restart_delay    = 600;
    localparam int clk_period_ns    = 10;

    // name, fill, frames started, extra start mid-frame, expected frame_done pulses
    string test_names      [num_tests] = '{"zeros", "ones", "col_ramp", "lcg"};
    fill_t test_fills      [num_tests] = '{fill_zeros, fill_ones, fill_ramp, fill_lcg};
    int    test_frames     [num_tests] = '{1, 1, 1, 2};
    bit    test_restart    [num_tests] = '{1'b0, 1'b1, 1'b0, 1'b1};
    int    test_done_count [num_tests] = '{1, 1, 1, 2};

    logic        clk_in;
    logic        reset;
    logic        frame_start;
    logic        wr_en;
    mem_addr_t   wr_addr;
    ram_word_t   wr_data;
    rgb_bits_t   rgb_top;
    rgb_bits_t   rgb_bottom;
    logic        panel_clk;
    logic        latch;
    logic        oe_n;
    row_addr_t   row_out;
    logic        frame_done;
    logic        scan_enable;
    logic        test_done;
    int          frames_expected;
    int          error_count;
    logic [31:0] lcg_state;
    int          tests_run;
    int          failed_tests;

    tb_clock_gen i_tb_clock_gen (
        .clk_in(clk_in),
        .reset (reset)
    );

    led_panel_top i_led_panel_top (
        .clk_in     (clk_in),
        .reset      (reset),
        .frame_start(frame_start),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .rgb_top    (rgb_top),
        .rgb_bottom (rgb_bottom),
        .panel_clk  (panel_clk),
        .latch      (latch),
        .oe_n       (oe_n),
        .row_out    (row_out),
        .frame_done (frame_done)
    );

    panel_checker i_panel_checker (
        .clk_in         (clk_in),
        .reset          (reset),
        .rgb_top        (rgb_top),
        .rgb_bottom     (rgb_bottom),
        .panel_clk      (panel_clk),
        .latch          (latch),
        .oe_n           (oe_n),
        .row_out        (row_out),
        .frame_done     (frame_done),
        .scan_enable    (scan_enable),
        .test_done      (test_done),
        .frames_expected(frames_expected),
        .error_count    (error_count)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic int watchdog_limit_ns();
        int cycles;
        int t;
        // reset and idle check, then writes, frames and settling per test
        cycles = 200;
        for (t = 0; t < num_tests; t++) begin
            cycles += write_cycles + frame_cycles_max * test_frames[test_index_t'(t)]
                      + 2 * settle_cycles;
        end
        return 2 * cycles * clk_period_ns;
    endfunction

    function automatic int error_total();
        return error_count + i_led_panel_top.i_led_panel_asserts.latch_failures
               + i_led_panel_top.i_led_panel_asserts.blank_failures
               + i_led_panel_top.i_led_panel_asserts.fetch_failures;
    endfunction

    task automatic write_frame(input fill_t fill);
        int        a;
        mem_addr_t addr;
        ram_word_t word;
        for (a = 0; a < write_cycles; a++) begin
            addr = mem_addr_t'(a);
            case (fill)
                fill_zeros: word = '0;
                fill_ones:  word = '1;
                // bottom {row, col, col}, top {col, row, col}
                fill_ramp:  word = {addr[9:6], addr[5:0], addr[5:0],
                                    addr[5:0], addr[9:6], addr[5:0]};
                default: begin
                    lcg_state = lcg_next(lcg_state);
                    word      = lcg_state;
                end
            endcase
            @(posedge clk_in);
            #1;
            wr_en   = 1'b1;
            wr_addr = addr;
            wr_data = word;
            i_panel_checker.model[addr] = word;
        end
        @(posedge clk_in);
        #1;
        wr_en = 1'b0;
    endtask

    task automatic pulse_frame_start();
        @(posedge clk_in);
        #1;
        frame_start = 1'b1;
        @(posedge clk_in);
        #1;
        frame_start = 1'b0;
    endtask

    task automatic wait_frame_done();
        @(negedge clk_in);
        while (frame_done !== 1'b1) begin
            @(negedge clk_in);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        int test_errors;
        test_errors = error_total() - errors_before;
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: failed with %0d errors", name, test_errors);
        end
    endtask

    initial begin : main
        int          t;
        int          f;
        int          errors_before;
        test_index_t idx;
        frame_start     = 1'b0;
        wr_en           = 1'b0;
        wr_addr         = '0;
        wr_data         = '0;
        scan_enable     = 1'b0;
        test_done       = 1'b0;
        frames_expected = 0;
        lcg_state       = 32'd25815;
        tests_run       = 0;
        failed_tests    = 0;
        i_panel_checker.test_name = "reset_idle";
        wait (reset == 1'b0);
        // pins must stay quiet before any frame
        errors_before = error_total();
        repeat (settle_cycles) @(posedge clk_in);
        report_test("reset_idle", errors_before);

        for (t = 0; t < num_tests; t++) begin
            idx = test_index_t'(t);
            i_panel_checker.test_name = test_names[idx];
            errors_before = error_total();
            write_frame(test_fills[idx]);
            @(posedge clk_in);
            #1;
            scan_enable = 1'b1;
            for (f = 0; f < test_frames[idx]; f++) begin
                pulse_frame_start();
                if (test_restart[idx] && f == 0) begin
                    // a start while busy must be dropped
                    repeat (restart_delay) @(posedge clk_in);
                    pulse_frame_start();
                end
                wait_frame_done();
            end
            @(posedge clk_in);
            #1;
            scan_enable = 1'b0;
            repeat (settle_cycles) @(posedge clk_in);
            #1;
            frames_expected = test_done_count[idx];
            test_done       = 1'b1;
            @(posedge clk_in);
            #1;
            test_done = 1'b0;
            report_test(test_names[idx], errors_before);
        end

        $display("tests run %0d, failed %0d, errors %0d", tests_run, failed_tests,
                 error_total());
        if (failed_tests == 0 && error_total() == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin : watchdog
        int limit_ns;
        limit_ns = watchdog_limit_ns();
        #(limit_ns);
        $display("ERROR: watchdog expired after %0d ns, frame_done never arrived", limit_ns);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/panel_checker.sv
// --------------------------------------------------------------------------
// panel pin checker: framebuffer model, pixel, latch, row and frame
// count comparison, idle pin checks and error counting
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module panel_checker (
    input  logic                     clk_in,
    input  logic                     reset,
    input  led_panel_pkg::rgb_bits_t rgb_top,
    input  led_panel_pkg::rgb_bits_t rgb_bottom,
    input  logic                     panel_clk,
    input  logic                     latch,
    input  logic                     oe_n,
    input  led_panel_pkg::row_addr_t row_out,
    input  logic                     frame_done,
    input  logic                     scan_enable,
    input  logic                     test_done,
    input  int                       frames_expected,
    output int                       error_count
);
    import led_panel_pkg::*;

    // image of the framebuffer, filled by the testbench
    ram_word_t model [panel_width * panel_half_height];
    string     test_name;
    logic      prev_clk;
    logic      prev_latch;
    logic      prev_done;
    int        col_count;
    int        row_count;
    int        frames_seen;

    // rgb565 channel msbs, red first
    function automatic rgb_bits_t colour_msbs(input pixel_t p);
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
        red   = p[15:11];
        green = p[10:5];
        blue  = p[4:0];
        return {red[4], green[5], blue[4]};
    endfunction

    task automatic check_shift();
        ram_word_t word;
        rgb_bits_t exp_top;
        rgb_bits_t exp_bottom;
        if (!oe_n && col_count < panel_width && row_count < panel_half_height) begin
            word       = model[mem_addr_t'(row_count * panel_width + col_count)];
            exp_top    = colour_msbs(word[15:0]);
            exp_bottom = colour_msbs(word[31:16]);
            if (rgb_top !== exp_top) begin
                $display("FAIL %s row %0d col %0d rgb_top expected %b actual %b",
                         test_name, row_count, col_count, exp_top, rgb_top);
                error_count++;
            end
            if (rgb_bottom !== exp_bottom) begin
                $display("FAIL %s row %0d col %0d rgb_bottom expected %b actual %b",
                         test_name, row_count, col_count, exp_bottom, rgb_bottom);
                error_count++;
            end
        end else begin
            $display("ERROR %s: panel_clk pulse with oe_n high or beyond the row end",
                     test_name);
            error_count++;
        end
        col_count++;
    endtask

    task automatic check_latch();
        if (col_count != panel_width) begin
            $display("FAIL %s row %0d panel_clk pulses expected %0d actual %0d",
                     test_name, row_count, panel_width, col_count);
            error_count++;
        end
        if (row_out !== row_addr_t'(row_count)) begin
            $display("FAIL %s latch row_out expected %0d actual %0d",
                     test_name, row_count, row_out);
            error_count++;
        end
        row_count++;
        col_count = 0;
    endtask

    always @(negedge clk_in) begin
        if (reset) begin
            prev_clk    = 1'b0;
            prev_latch  = 1'b0;
            prev_done   = 1'b0;
            col_count   = 0;
            row_count   = 0;
            frames_seen = 0;
            error_count = 0;
        end else begin
            if (!scan_enable) begin
                if (panel_clk || latch || frame_done || !oe_n) begin
                    $display("ERROR %s: panel pins active while no frame is running",
                             test_name);
                    error_count++;
                end
            end else begin
                if (panel_clk && !prev_clk) begin
                    check_shift();
                end
                if (latch && !prev_latch) begin
                    check_latch();
                end
                if (frame_done && !prev_done) begin
                    if (row_count != panel_half_height) begin
                        $display("FAIL %s latches per frame expected %0d actual %0d",
                                 test_name, panel_half_height, row_count);
                        error_count++;
                    end
                    row_count = 0;
                    frames_seen++;
                end
            end
            if (test_done) begin
                if (frames_seen != frames_expected) begin
                    $display("FAIL %s frame_done pulses expected %0d actual %0d",
                             test_name, frames_expected, frames_seen);
                    error_count++;
                end
                frames_seen = 0;
            end
            prev_clk   = panel_clk;
            prev_latch = latch;
            prev_done  = frame_done;
        end
    end

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
// --------------------------------------------------------------------------
// testbench clock and reset generator
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_in,
    output logic reset
);

    // 10 ns period
    initial begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    // reset held over 8 rising edges
    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk_in);
        #1;
        reset = 1'b0;
    end

endmodule

`default_nettype wire
